// File: common/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] mbe_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic {
        src1_rs1,
        src1_pc
    } alu_src1_t;

    typedef enum logic [2:0] {
        src2_rs2,
        src2_i_imm,
        src2_s_imm,
        src2_u_imm,
        src2_j_imm
    } alu_src2_t;

    typedef enum logic [2:0] {
        wb_alu,
        wb_load_word,
        wb_load_byte,
        wb_load_byte_unsigned,
        wb_u_imm,
        wb_pc_plus4
    } wb_sel_t;

    // copied unchanged through ID/EX, EX/MEM and MEM/WB
    typedef struct packed {
        rv32i_word instr;
        alu_src1_t src1_sel;
        alu_src2_t src2_sel;
        alu_op_t alu_op;
        logic [2:0] br_cond;
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic mem_read;
        logic mem_write;
        logic store_byte;
        wb_sel_t wb_sel;
        logic reg_write;
        reg_idx_t dest;
    } ctrl_word_t;

    // all zero, so no memory access and no register write
    localparam ctrl_word_t nop_ctrl = '0;

endpackage

// File: decode/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  rv32i_pkg::rv32i_word  instr,
    output rv32i_pkg::ctrl_word_t ctrl
);

    rv32i_pkg::rv32i_opcode opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv32i_pkg::ctrl_word_t dec;
    logic valid;

    // funct3 plus the alternate bit (funct7[5]) to an alu op
    function automatic rv32i_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        rv32i_pkg::alu_op_t sel;
        case (f3)
            3'b000:  sel = alt ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001:  sel = rv32i_pkg::alu_sll;
            3'b010:  sel = rv32i_pkg::alu_slt;
            3'b011:  sel = rv32i_pkg::alu_sltu;
            3'b100:  sel = rv32i_pkg::alu_xor;
            3'b101:  sel = alt ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110:  sel = rv32i_pkg::alu_or;
            default: sel = rv32i_pkg::alu_and;
        endcase
        return sel;
    endfunction

    assign opcode = rv32i_pkg::rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec = rv32i_pkg::nop_ctrl;
        valid = 1'b0;
        dec.instr = instr;
        dec.br_cond = funct3;
        case (opcode)
            rv32i_pkg::op_reg: begin
                // only add/sub and srl/sra have an alternate encoding
                valid = (funct7 == 7'b0000000)
                    || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                dec.src2_sel = rv32i_pkg::src2_rs2;
                dec.alu_op = arith_op(funct3, funct7[5]);
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_imm: begin
                if (funct3 == 3'b001) begin
                    valid = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    valid = 1'b1;
                end
                dec.src2_sel = rv32i_pkg::src2_i_imm;
                // no subi, so bit 30 only matters for the shift
                dec.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_lui: begin
                valid = 1'b1;
                dec.wb_sel = rv32i_pkg::wb_u_imm;
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_auipc: begin
                valid = 1'b1;
                dec.src1_sel = rv32i_pkg::src1_pc;
                dec.src2_sel = rv32i_pkg::src2_u_imm;
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_br: begin
                valid = (funct3 != 3'b010) && (funct3 != 3'b011);
                dec.src2_sel = rv32i_pkg::src2_rs2;
                dec.alu_op = funct3[1] ? rv32i_pkg::alu_sltu : rv32i_pkg::alu_slt;
                dec.is_branch = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                valid = 1'b1;
                dec.src1_sel = rv32i_pkg::src1_pc;
                dec.src2_sel = rv32i_pkg::src2_j_imm;
                dec.is_jal = 1'b1;
                dec.wb_sel = rv32i_pkg::wb_pc_plus4;
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_jalr: begin
                valid = (funct3 == 3'b000);
                dec.src2_sel = rv32i_pkg::src2_i_imm;
                dec.is_jalr = 1'b1;
                dec.wb_sel = rv32i_pkg::wb_pc_plus4;
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_load: begin
                // lb, lw and lbu only
                valid = (funct3 == 3'b000) || (funct3 == 3'b010) || (funct3 == 3'b100);
                dec.src2_sel = rv32i_pkg::src2_i_imm;
                dec.mem_read = 1'b1;
                case (funct3)
                    3'b000:  dec.wb_sel = rv32i_pkg::wb_load_byte;
                    3'b100:  dec.wb_sel = rv32i_pkg::wb_load_byte_unsigned;
                    default: dec.wb_sel = rv32i_pkg::wb_load_word;
                endcase
                dec.reg_write = 1'b1;
            end
            rv32i_pkg::op_store: begin
                valid = (funct3 == 3'b000) || (funct3 == 3'b010);
                dec.src2_sel = rv32i_pkg::src2_s_imm;
                dec.mem_write = 1'b1;
                dec.store_byte = (funct3 == 3'b000);
            end
            default: begin
                valid = 1'b0;
            end
        endcase
        dec.dest = dec.reg_write ? instr[11:7] : 5'd0;
        ctrl = valid ? dec : rv32i_pkg::nop_ctrl;
    end

endmodule

// File: decode/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 write_en,
    input  rv32i_pkg::reg_idx_t  write_idx,
    input  rv32i_pkg::reg_idx_t  read_idx1,
    input  rv32i_pkg::reg_idx_t  read_idx2,
    input  rv32i_pkg::rv32i_word write_data,
    output rv32i_pkg::rv32i_word read_data1,
    output rv32i_pkg::rv32i_word read_data2
);

    // x0 has no storage
    rv32i_pkg::rv32i_word regs [1:31];
    logic do_write;

    assign do_write = write_en && (write_idx != 5'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[write_idx] <= write_data;
        end
    end

    // write-through, so a reader three slots behind the writer sees the new value
    assign read_data1 = (read_idx1 == 5'd0) ? '0 :
                        (do_write && write_idx == read_idx1) ? write_data : regs[read_idx1];
    assign read_data2 = (read_idx2 == 5'd0) ? '0 :
                        (do_write && write_idx == read_idx2) ? write_data : regs[read_idx2];

endmodule

// File: dv/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;

    localparam int per_test_cycles = 150;
    localparam int num_tests = 5;
    // each test also spends a few cycles in reset
    localparam int cycle_limit = num_tests * (per_test_cycles + 8);
    localparam rv32i_pkg::rv32i_word marker_addr = 32'h0000_03fc;
    localparam rv32i_pkg::rv32i_word nop_word = 32'h0000_0013;

    logic clk = 1'b0;
    logic arst_n;
    rv32i_pkg::rv32i_word inst_addr;
    rv32i_pkg::rv32i_word inst_rdata;
    rv32i_pkg::rv32i_word data_addr;
    rv32i_pkg::rv32i_word data_wdata;
    rv32i_pkg::rv32i_word data_rdata;
    rv32i_pkg::mbe_t data_mbe;
    logic data_read;
    logic data_write;

    integer seed = 83568;
    int cycles = 0;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit marker_seen = 1'b0;
    rv32i_pkg::rv32i_word prog[$];
    rv32i_pkg::rv32i_word exp_addr[$];
    rv32i_pkg::rv32i_word exp_data[$];
    rv32i_pkg::mbe_t exp_mbe[$];
    rv32i_pkg::rv32i_word seen_addr[$];
    rv32i_pkg::rv32i_word seen_data[$];
    rv32i_pkg::mbe_t seen_mbe[$];

    always #10 clk = ~clk;

    datapath #(.RESET_PC(32'h0000_0000)) i_dut (
        .clk(clk),
        .arst_n(arst_n),
        .inst_rdata(inst_rdata),
        .inst_addr(inst_addr),
        .data_rdata(data_rdata),
        .data_addr(data_addr),
        .data_wdata(data_wdata),
        .data_mbe(data_mbe),
        .data_read(data_read),
        .data_write(data_write)
    );

    tb_memory i_imem (
        .clk(clk),
        .addr(inst_addr),
        .wdata(32'h0000_0000),
        .mbe(4'b0000),
        .write(1'b0),
        .rdata(inst_rdata)
    );

    tb_memory i_dmem (
        .clk(clk),
        .addr(data_addr),
        .wdata(data_wdata),
        .mbe(data_mbe),
        .write(data_write),
        .rdata(data_rdata)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run stopped: no result after %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // record stores mid-cycle, where the memory-stage outputs are settled
    always @(negedge clk) begin
        if (arst_n && data_write) begin
            if (data_addr == marker_addr) begin
                marker_seen = 1'b1;
            end else begin
                seen_addr.push_back(data_addr);
                seen_data.push_back(data_wdata);
                seen_mbe.push_back(data_mbe);
            end
        end
    end

    // instruction encoders
    function automatic rv32i_pkg::rv32i_word r_type(input int f7, input int rs2, input int rs1,
                                                    input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic rv32i_pkg::rv32i_word i_type(input rv32i_pkg::rv32i_word imm,
                                                    input int rs1, input int f3, input int rd,
                                                    input int op);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
    endfunction

    function automatic rv32i_pkg::rv32i_word s_type(input rv32i_pkg::rv32i_word imm,
                                                    input int rs2, input int f3);
        return {imm[11:5], 5'(rs2), 5'd0, 3'(f3), imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_pkg::rv32i_word b_type(input rv32i_pkg::rv32i_word off,
                                                    input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'(f3), off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv32i_pkg::rv32i_word u_type(input rv32i_pkg::rv32i_word upper,
                                                    input int rd, input int op);
        return {upper[19:0], 5'(rd), 7'(op)};
    endfunction

    function automatic rv32i_pkg::rv32i_word j_type(input rv32i_pkg::rv32i_word off,
                                                    input int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
    endfunction

    // reference arithmetic from the RV32I definitions
    function automatic rv32i_pkg::rv32i_word expected_alu(input int f3, input bit alt,
                                                          input rv32i_pkg::rv32i_word a,
                                                          input rv32i_pkg::rv32i_word b);
        rv32i_pkg::rv32i_word r;
        case (f3)
            0:       r = alt ? a - b : a + b;
            1:       r = a << b[4:0];
            2:       r = {31'd0, $signed(a) < $signed(b)};
            3:       r = {31'd0, a < b};
            4:       r = a ^ b;
            5:       r = alt ? rv32i_pkg::rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6:       r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic rv32i_pkg::rv32i_word sext_byte(input logic [7:0] v);
        return {{24{v[7]}}, v};
    endfunction

    function automatic rv32i_pkg::rv32i_word next_pc();
        return rv32i_pkg::rv32i_word'(prog.size() * 4);
    endfunction

    task automatic emit(input rv32i_pkg::rv32i_word w);
        prog.push_back(w);
    endtask

    task automatic pad(input int n);
        repeat (n) prog.push_back(nop_word);
    endtask

    // lui plus addi, with the lui rounded for the sign of the low part
    task automatic load_const(input int rd, input rv32i_pkg::rv32i_word v);
        rv32i_pkg::rv32i_word upper;
        upper = {12'd0, v[31:12] + {19'd0, v[11]}};
        emit(u_type(upper, rd, int'(rv32i_pkg::op_lui)));
        pad(2);
        emit(i_type(v, rd, 0, rd, int'(rv32i_pkg::op_imm)));
    endtask

    task automatic store_word(input int rs2, input rv32i_pkg::rv32i_word addr,
                              input rv32i_pkg::rv32i_word value);
        emit(s_type(addr, rs2, 2));
        exp_addr.push_back(addr);
        exp_data.push_back(value);
        exp_mbe.push_back(4'b1111);
    endtask

    task automatic store_byte(input int rs2, input rv32i_pkg::rv32i_word addr,
                              input logic [7:0] value);
        rv32i_pkg::mbe_t lane_mask;
        // one enable, for the addressed lane
        for (int l = 0; l < 4; l++) begin
            lane_mask[l] = (addr[1:0] == 2'(l));
        end
        emit(s_type(addr, rs2, 0));
        exp_addr.push_back(addr);
        exp_data.push_back({4{value}});
        exp_mbe.push_back(lane_mask);
    endtask

    task automatic check_word(input string name, input rv32i_pkg::rv32i_word expected,
                              input rv32i_pkg::rv32i_word actual);
        if (expected !== actual) begin
            $display("Error: %s expected %08h got %08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_mbe(input string name, input rv32i_pkg::mbe_t expected,
                             input rv32i_pkg::mbe_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %01h got %01h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        errors = 0;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_mbe.delete();
    endtask

    task automatic end_test(input string name);
        if (errors == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors);
        end
    endtask

    // reset held for 4 cycles while the memories are loaded
    task automatic start_program();
        arst_n = 1'b0;
        marker_seen = 1'b0;
        seen_addr.delete();
        seen_data.delete();
        seen_mbe.delete();
        for (int i = 0; i < 256; i++) begin
            i_imem.words[i] <= nop_word;
            i_dmem.words[i] <= 32'hd0a0_0000 | rv32i_pkg::rv32i_word'(i * 32'h0101);
        end
        for (int i = 0; i < prog.size(); i++) begin
            i_imem.words[i] <= prog[i];
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic run_program(input string name);
        int n;
        int count;
        n = 0;
        emit(s_type(marker_addr, 0, 2));
        pad(4);
        start_program();
        arst_n = 1'b1;
        while (!marker_seen && n < per_test_cycles) begin
            @(posedge clk);
            n++;
        end
        #2;
        if (!marker_seen) begin
            $display("%s: final marker store did not appear in %0d cycles", name, n);
            errors++;
        end
        if (seen_addr.size() != exp_addr.size()) begin
            $display("%s: expected %0d data writes but saw %0d", name, exp_addr.size(),
                     seen_addr.size());
            errors++;
        end
        count = (seen_addr.size() < exp_addr.size()) ? seen_addr.size() : exp_addr.size();
        for (int i = 0; i < count; i++) begin
            check_word("data_addr", exp_addr[i], seen_addr[i]);
            check_word("data_wdata", exp_data[i], seen_data[i]);
            check_mbe("data_mbe", exp_mbe[i], seen_mbe[i]);
        end
    endtask

    task automatic reset_test();
        begin_test();
        start_program();
        check_word("inst_addr", 32'h0, inst_addr);
        check_word("data_read", 32'h0, {31'd0, data_read});
        check_word("data_write", 32'h0, {31'd0, data_write});
        arst_n = 1'b1;
        for (int k = 1; k <= 4; k++) begin
            @(posedge clk);
            #2;
            check_word("inst_addr", rv32i_pkg::rv32i_word'(4 * k), inst_addr);
            check_word("data_write", 32'h0, {31'd0, data_write});
        end
        end_test("reset");
    endtask

    task automatic alu_test();
        rv32i_pkg::rv32i_word a;
        rv32i_pkg::rv32i_word b;
        rv32i_pkg::rv32i_word bimm;
        rv32i_pkg::rv32i_word shamt;
        rv32i_pkg::rv32i_word results [19];
        int imm_f3 [6] = '{0, 2, 3, 4, 6, 7};
        begin_test();
        a = $random(seed);
        b = $random(seed);
        bimm = {{20{b[11]}}, b[11:0]};
        shamt = {27'd0, b[4:0]};
        load_const(1, a);
        load_const(2, b);
        pad(2);
        for (int k = 0; k < 8; k++) begin
            emit(r_type(0, 2, 1, k, 3 + k));
            results[k] = expected_alu(k, 1'b0, a, b);
        end
        emit(r_type(32, 2, 1, 0, 11));
        results[8] = expected_alu(0, 1'b1, a, b);
        emit(r_type(32, 2, 1, 5, 12));
        results[9] = expected_alu(5, 1'b1, a, b);
        for (int k = 0; k < 6; k++) begin
            emit(i_type(bimm, 1, imm_f3[k], 13 + k, int'(rv32i_pkg::op_imm)));
            results[10 + k] = expected_alu(imm_f3[k], 1'b0, a, bimm);
        end
        emit(i_type(shamt, 1, 1, 19, int'(rv32i_pkg::op_imm)));
        results[16] = expected_alu(1, 1'b0, a, shamt);
        emit(i_type(shamt, 1, 5, 20, int'(rv32i_pkg::op_imm)));
        results[17] = expected_alu(5, 1'b0, a, shamt);
        emit(i_type(32'h400 | shamt, 1, 5, 21, int'(rv32i_pkg::op_imm)));
        results[18] = expected_alu(5, 1'b1, a, shamt);
        for (int k = 0; k < 19; k++) begin
            store_word(3 + k, 32'h100 + rv32i_pkg::rv32i_word'(4 * k), results[k]);
        end
        run_program("alu");
        end_test("alu");
    endtask

    task automatic upper_test();
        rv32i_pkg::rv32i_word u1;
        rv32i_pkg::rv32i_word u2;
        rv32i_pkg::rv32i_word u3;
        rv32i_pkg::rv32i_word pc2;
        rv32i_pkg::rv32i_word pc3;
        begin_test();
        u1 = $random(seed);
        u2 = $random(seed);
        u3 = $random(seed);
        emit(u_type(u1, 5, int'(rv32i_pkg::op_lui)));
        pc2 = next_pc();
        emit(u_type(u2, 6, int'(rv32i_pkg::op_auipc)));
        pad(1);
        pc3 = next_pc();
        emit(u_type(u3, 7, int'(rv32i_pkg::op_auipc)));
        pad(2);
        store_word(5, 32'h180, {u1[19:0], 12'h000});
        store_word(6, 32'h184, {u2[19:0], 12'h000} + pc2);
        store_word(7, 32'h188, {u3[19:0], 12'h000} + pc3);
        run_program("upper");
        end_test("upper");
    endtask

    task automatic load_store_test();
        rv32i_pkg::rv32i_word w;
        rv32i_pkg::rv32i_word v;
        int ld;
        begin_test();
        ld = int'(rv32i_pkg::op_load);
        w = $random(seed);
        v = $random(seed);
        // byte 3 and 1 negative, byte 2 and 0 positive
        w[31] = 1'b1;
        w[23] = 1'b0;
        w[15] = 1'b1;
        w[7] = 1'b0;
        load_const(1, w);
        load_const(2, v);
        pad(2);
        store_word(1, 32'h200, w);
        for (int lane = 0; lane < 4; lane++) begin
            store_byte(2, 32'h210 + rv32i_pkg::rv32i_word'(lane), v[7:0]);
        end
        emit(i_type(32'h200, 0, 2, 3, ld));
        emit(i_type(32'h203, 0, 0, 4, ld));
        emit(i_type(32'h202, 0, 0, 5, ld));
        emit(i_type(32'h201, 0, 4, 6, ld));
        emit(i_type(32'h200, 0, 4, 7, ld));
        emit(i_type(32'h210, 0, 2, 8, ld));
        pad(2);
        store_word(3, 32'h220, w);
        store_word(4, 32'h224, sext_byte(w[31:24]));
        store_word(5, 32'h228, sext_byte(w[23:16]));
        store_word(6, 32'h22c, {24'd0, w[15:8]});
        store_word(7, 32'h230, {24'd0, w[7:0]});
        store_word(8, 32'h234, {4{v[7:0]}});
        run_program("load_store");
        end_test("load_store");
    endtask

    // x10..x21 change only when their branch falls through
    task automatic branch_test();
        int br_f3 [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        int br_rs1 [12] = '{4, 3, 3, 4, 3, 4, 4, 3, 4, 3, 3, 4};
        int br_rs2 [12] = '{4, 4, 4, 4, 4, 3, 3, 4, 3, 4, 4, 3};
        bit br_taken [12] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};
        int fix_idx;
        int opi;
        rv32i_pkg::rv32i_word jal_pc;
        rv32i_pkg::rv32i_word jalr_pc;
        rv32i_pkg::rv32i_word jalr_base;
        begin_test();
        opi = int'(rv32i_pkg::op_imm);
        emit(i_type(32'hfff, 0, 0, 3, opi));
        emit(i_type(32'h001, 0, 0, 4, opi));
        fix_idx = prog.size();
        emit(nop_word);
        pad(2);
        for (int k = 0; k < 12; k++) begin
            emit(b_type(32'd20, br_rs2[k], br_rs1[k], br_f3[k]));
            pad(3);
            emit(i_type(rv32i_pkg::rv32i_word'(k + 1), 0, 0, 10 + k, opi));
        end
        jal_pc = next_pc();
        emit(j_type(32'd20, 22));
        pad(3);
        emit(i_type(32'h055, 0, 0, 24, opi));
        jalr_pc = next_pc();
        emit(i_type(32'h0, 25, 0, 23, int'(rv32i_pkg::op_jalr)));
        pad(3);
        emit(i_type(32'h066, 0, 0, 24, opi));
        // jalr lands here, auipc records the landing pc
        emit(u_type(32'h0, 26, int'(rv32i_pkg::op_auipc)));
        // odd jalr base, the core clears bit 0
        jalr_base = jalr_pc + 32'd21;
        prog[fix_idx] = i_type(jalr_base, 0, 0, 25, opi);
        for (int k = 0; k < 12; k++) begin
            store_word(10 + k, 32'h100 + rv32i_pkg::rv32i_word'(4 * k),
                       br_taken[k] ? 32'h0 : rv32i_pkg::rv32i_word'(k + 1));
        end
        store_word(22, 32'h140, jal_pc + 32'd4);
        store_word(23, 32'h144, jalr_pc + 32'd4);
        store_word(24, 32'h148, 32'h0);
        store_word(26, 32'h14c, jalr_base & 32'hffff_fffe);
        run_program("branch");
        end_test("branch");
    endtask

    initial begin
        arst_n = 1'b0;
        reset_test();
        alu_test();
        upper_test();
        load_store_test();
        branch_test();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input  logic                 clk,
    input  rv32i_pkg::rv32i_word addr,
    input  rv32i_pkg::rv32i_word wdata,
    input  rv32i_pkg::mbe_t      mbe,
    input  logic                 write,
    output rv32i_pkg::rv32i_word rdata
);

    // 1 KB, word addressed by addr[9:2]
    rv32i_pkg::rv32i_word words [0:255];
    logic [7:0] index;

    assign index = addr[9:2];

    // same-cycle read, no wait states
    assign rdata = words[index];

    always @(posedge clk) begin
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (mbe[b]) begin
                    words[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: execute/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv32i_pkg::alu_op_t   op,
    input  rv32i_pkg::rv32i_word a,
    input  rv32i_pkg::rv32i_word b,
    output rv32i_pkg::rv32i_word f,
    output logic                 equal,
    output logic                 less_signed,
    output logic                 less_unsigned
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare flags are independent of op, the branch logic reads them
    assign equal = (a == b);
    assign less_signed = ($signed(a) < $signed(b));
    assign less_unsigned = (a < b);

    always_comb begin
        case (op)
            rv32i_pkg::alu_add:  f = a + b;
            rv32i_pkg::alu_sub:  f = a - b;
            rv32i_pkg::alu_sll:  f = a << shamt;
            rv32i_pkg::alu_slt:  f = {31'd0, less_signed};
            rv32i_pkg::alu_sltu: f = {31'd0, less_unsigned};
            rv32i_pkg::alu_xor:  f = a ^ b;
            rv32i_pkg::alu_srl:  f = a >> shamt;
            rv32i_pkg::alu_sra:  f = $signed(a) >>> shamt;
            rv32i_pkg::alu_or:   f = a | b;
            rv32i_pkg::alu_and:  f = a & b;
            default:             f = a + b;
        endcase
    end

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  rv32i_pkg::ctrl_word_t ctrl,
    input  rv32i_pkg::rv32i_word  pc,
    input  rv32i_pkg::rv32i_word  rs1_value,
    input  rv32i_pkg::rv32i_word  rs2_value,
    output rv32i_pkg::rv32i_word  result,
    output rv32i_pkg::rv32i_word  target,
    output logic                  taken
);

    rv32i_pkg::rv32i_word i_imm;
    rv32i_pkg::rv32i_word s_imm;
    rv32i_pkg::rv32i_word b_imm;
    rv32i_pkg::rv32i_word u_imm;
    rv32i_pkg::rv32i_word j_imm;
    rv32i_pkg::rv32i_word operand_a;
    rv32i_pkg::rv32i_word operand_b;
    rv32i_pkg::rv32i_word alu_f;
    logic equal;
    logic less_signed;
    logic less_unsigned;
    logic cond_true;

    assign i_imm = {{21{ctrl.instr[31]}}, ctrl.instr[30:20]};
    assign s_imm = {{21{ctrl.instr[31]}}, ctrl.instr[30:25], ctrl.instr[11:7]};
    assign b_imm = {{20{ctrl.instr[31]}}, ctrl.instr[7], ctrl.instr[30:25],
                    ctrl.instr[11:8], 1'b0};
    assign u_imm = {ctrl.instr[31:12], 12'h000};
    assign j_imm = {{12{ctrl.instr[31]}}, ctrl.instr[19:12], ctrl.instr[20],
                    ctrl.instr[30:21], 1'b0};

    always_comb begin
        operand_a = (ctrl.src1_sel == rv32i_pkg::src1_pc) ? pc : rs1_value;
        case (ctrl.src2_sel)
            rv32i_pkg::src2_i_imm: operand_b = i_imm;
            rv32i_pkg::src2_s_imm: operand_b = s_imm;
            rv32i_pkg::src2_u_imm: operand_b = u_imm;
            rv32i_pkg::src2_j_imm: operand_b = j_imm;
            default:               operand_b = rs2_value;
        endcase
    end

    alu i_alu (
        .op(ctrl.alu_op),
        .a(operand_a),
        .b(operand_b),
        .f(alu_f),
        .equal(equal),
        .less_signed(less_signed),
        .less_unsigned(less_unsigned)
    );

    // branch condition from funct3
    always_comb begin
        case (ctrl.br_cond)
            3'b000:  cond_true = equal;
            3'b001:  cond_true = !equal;
            3'b100:  cond_true = less_signed;
            3'b101:  cond_true = !less_signed;
            3'b110:  cond_true = less_unsigned;
            default: cond_true = !less_unsigned;
        endcase
    end

    assign result = alu_f;
    // jalr target is rs1 + imm from the alu, bit 0 cleared later in the mem stage
    assign target = ctrl.is_jalr ? alu_f : pc + (ctrl.is_jal ? j_imm : b_imm);
    assign taken = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond_true);

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv32i_pkg::rv32i_word inst_rdata,
    output rv32i_pkg::rv32i_word inst_addr,
    input  rv32i_pkg::rv32i_word data_rdata,
    output rv32i_pkg::rv32i_word data_addr,
    output rv32i_pkg::rv32i_word data_wdata,
    output rv32i_pkg::mbe_t      data_mbe,
    output logic                 data_read,
    output logic                 data_write
);

    // fetch
    rv32i_pkg::rv32i_word pc;
    rv32i_pkg::rv32i_word pc_next;

    // decode
    rv32i_pkg::rv32i_word instr_id;
    rv32i_pkg::rv32i_word pc_id;
    rv32i_pkg::ctrl_word_t ctrl_id;
    rv32i_pkg::rv32i_word rs1_id;
    rv32i_pkg::rv32i_word rs2_id;

    // execute
    rv32i_pkg::ctrl_word_t ctrl_ex;
    rv32i_pkg::rv32i_word pc_ex;
    rv32i_pkg::rv32i_word rs1_ex;
    rv32i_pkg::rv32i_word rs2_ex;
    rv32i_pkg::rv32i_word alu_ex;
    rv32i_pkg::rv32i_word target_ex;
    logic taken_ex;

    // memory
    rv32i_pkg::ctrl_word_t ctrl_mem;
    rv32i_pkg::rv32i_word pc_mem;
    rv32i_pkg::rv32i_word alu_mem;
    rv32i_pkg::rv32i_word target_mem;
    rv32i_pkg::rv32i_word rs2_mem;
    logic taken_mem;

    // writeback
    rv32i_pkg::ctrl_word_t ctrl_wb;
    rv32i_pkg::rv32i_word pc_wb;
    rv32i_pkg::rv32i_word alu_wb;
    rv32i_pkg::rv32i_word load_wb;
    rv32i_pkg::rv32i_word wb_value;

    // redirect happens when the transfer reaches the mem stage
    always_comb begin
        if (taken_mem) begin
            pc_next = ctrl_mem.is_jalr ? {target_mem[31:1], 1'b0} : target_mem;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
            instr_id <= '0;
            ctrl_ex <= rv32i_pkg::nop_ctrl;
            ctrl_mem <= rv32i_pkg::nop_ctrl;
            ctrl_wb <= rv32i_pkg::nop_ctrl;
            taken_mem <= 1'b0;
        end else begin
            pc <= pc_next;
            instr_id <= inst_rdata;
            ctrl_ex <= ctrl_id;
            ctrl_mem <= ctrl_ex;
            ctrl_wb <= ctrl_mem;
            taken_mem <= taken_ex;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        pc_id <= pc;
        pc_ex <= pc_id;
        rs1_ex <= rs1_id;
        rs2_ex <= rs2_id;
        pc_mem <= pc_ex;
        alu_mem <= alu_ex;
        target_mem <= target_ex;
        rs2_mem <= rs2_ex;
        pc_wb <= pc_mem;
        alu_wb <= alu_mem;
        load_wb <= data_rdata;
    end

    control_unit i_control_unit (
        .instr(instr_id),
        .ctrl(ctrl_id)
    );

    regfile i_regfile (
        .clk(clk),
        .arst_n(arst_n),
        .write_en(ctrl_wb.reg_write),
        .write_idx(ctrl_wb.dest),
        .read_idx1(instr_id[19:15]),
        .read_idx2(instr_id[24:20]),
        .write_data(wb_value),
        .read_data1(rs1_id),
        .read_data2(rs2_id)
    );

    execute_stage i_execute_stage (
        .ctrl(ctrl_ex),
        .pc(pc_ex),
        .rs1_value(rs1_ex),
        .rs2_value(rs2_ex),
        .result(alu_ex),
        .target(target_ex),
        .taken(taken_ex)
    );

    result_select i_result_select (
        .ctrl(ctrl_wb),
        .alu_result(alu_wb),
        .load_data(load_wb),
        .pc(pc_wb),
        .byte_lane(alu_wb[1:0]),
        .wb_value(wb_value)
    );

    // sb puts the byte on every lane and enables only the addressed one
    always_comb begin
        if (ctrl_mem.store_byte) begin
            data_wdata = {4{rs2_mem[7:0]}};
            data_mbe = 4'b0001 << alu_mem[1:0];
        end else begin
            data_wdata = rs2_mem;
            data_mbe = 4'b1111;
        end
        if (!ctrl_mem.mem_write) begin
            data_mbe = 4'b0000;
        end
    end

    assign inst_addr = pc;
    assign data_addr = alu_mem;
    assign data_read = ctrl_mem.mem_read;
    assign data_write = ctrl_mem.mem_write;

endmodule

// File: hdl/result_select.sv
`timescale 1ns/1ps

module result_select (
    input  rv32i_pkg::ctrl_word_t ctrl,
    input  rv32i_pkg::rv32i_word  alu_result,
    input  rv32i_pkg::rv32i_word  load_data,
    input  rv32i_pkg::rv32i_word  pc,
    input  logic [1:0]            byte_lane,
    output rv32i_pkg::rv32i_word  wb_value
);

    logic [7:0] lane_byte;
    rv32i_pkg::rv32i_word u_imm;

    // memory returns the whole aligned word
    always_comb begin
        case (byte_lane)
            2'd0:    lane_byte = load_data[7:0];
            2'd1:    lane_byte = load_data[15:8];
            2'd2:    lane_byte = load_data[23:16];
            default: lane_byte = load_data[31:24];
        endcase
    end

    assign u_imm = {ctrl.instr[31:12], 12'h000};

    always_comb begin
        case (ctrl.wb_sel)
            rv32i_pkg::wb_load_word:          wb_value = load_data;
            rv32i_pkg::wb_load_byte:          wb_value = {{24{lane_byte[7]}}, lane_byte};
            rv32i_pkg::wb_load_byte_unsigned: wb_value = {24'd0, lane_byte};
            rv32i_pkg::wb_u_imm:              wb_value = u_imm;
            rv32i_pkg::wb_pc_plus4:           wb_value = pc + 32'd4;
            default:                          wb_value = alu_result;
        endcase
    end

endmodule

// File: project.f
common/rv32i_pkg.sv
decode/control_unit.sv
decode/regfile.sv
execute/alu.sv
execute/execute_stage.sv
hdl/result_select.sv
hdl/datapath.sv
dv/tb_memory.sv
dv/tb_datapath.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_datapath -f project.f -o sim_tb_datapath

output=$(./obj_dir/sim_tb_datapath)
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
